//--- Makefile
SRCS = $(shell cat vlog.f)

all: run

obj_dir/Vtb_wb_core: vlog.f $(SRCS)
	verilator --binary --assert -j 0 --top-module tb_wb_core -f vlog.f

run: obj_dir/Vtb_wb_core
	./obj_dir/Vtb_wb_core | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- sim/tb_wb_core.sv
`default_nettype none

module tb_wb_core;
    import wb_pkg::*;

    localparam int    QUEUE_DEPTH = 4;
    localparam int    CNT_W       = $clog2(QUEUE_DEPTH + 1);
    localparam word_t EENTRY      = 32'h1c00_8000;
    localparam word_t TLBRENTRY   = 32'h1c00_f000;
    localparam word_t PGDL        = 32'h0010_0000;
    localparam word_t PGDH        = 32'h0020_0000;

    typedef struct {
        int        grp;
        logic      s0_valid;
        logic      s1_valid;
        word_t     s0_pc;
        word_t     s1_pc;
        word_t     s0_inst;
        word_t     s1_inst;
        word_t     s0_data;
        word_t     s1_data;
        word_t     s0_badv;
        reg_addr_t s0_rd;
        reg_addr_t s1_rd;
        ecode_t    s0_ecode;
        logic      upd_badv;
        logic      upd_vppn;
    } pair_t;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             in_s0_valid;
    logic             in_s1_valid;
    word_t            in_s0_pc;
    word_t            in_s1_pc;
    word_t            in_s0_inst;
    word_t            in_s1_inst;
    word_t            in_s0_data;
    word_t            in_s1_data;
    word_t            in_s0_badv;
    reg_addr_t        in_s0_rd;
    reg_addr_t        in_s1_rd;
    ecode_t           in_s0_ecode;
    logic [CNT_W-1:0] credit_return;
    word_t            eentry;
    word_t            tlbrentry;
    word_t            pgdl;
    word_t            pgdh;
    reg_addr_t        rf_raddr;
    word_t            rf_rdata;
    word_t            dbg0_pc;
    word_t            dbg0_inst;
    word_t            dbg0_wdata;
    reg_addr_t        dbg0_wnum;
    logic             dbg0_wen;
    word_t            dbg1_pc;
    word_t            dbg1_inst;
    word_t            dbg1_wdata;
    reg_addr_t        dbg1_wnum;
    logic             dbg1_wen;
    word_t            csr_era;
    word_t            csr_badv;
    pgd_t             csr_pgd;
    ecode_t           csr_ecode;
    vppn_t            csr_vppn;
    logic             csr_direct_mode;
    logic             redirect_valid;
    word_t            redirect_pc;

    // stimulus table and reference model
    pair_t       tbl[$];
    int          model_q[$];
    word_t       model_rf[32];
    word_t       m_era;
    word_t       m_badv;
    pgd_t        m_pgd;
    ecode_t      m_ecode;
    vppn_t       m_vppn;
    logic        m_direct;
    logic        exp_redir;
    word_t       exp_redir_pc;
    logic [31:0] rng;
    int          next_idx;
    int          credits;
    int          sent_total;
    int          returned_total;
    int          errors;
    int          checks;
    int          tests;
    int          failed;
    int          cycle_count;
    int          timeout_limit;

    wb_core #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_wb_core (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout after %0d cycles, the queue never drained", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_entry(input int grp, input logic s0v, input logic s1v,
                             input reg_addr_t rd0, input reg_addr_t rd1,
                             input ecode_t code, input logic badv_hi,
                             input logic upd_badv, input logic upd_vppn);
        pair_t e;
        e.grp      = grp;
        e.s0_valid = s0v;
        e.s1_valid = s1v;
        e.s0_rd    = rd0;
        e.s1_rd    = rd1;
        e.s0_ecode = code;
        e.upd_badv = upd_badv;
        e.upd_vppn = upd_vppn;
        e.s0_pc    = 32'h1c00_0000 + 32'(tbl.size()) * 8;
        e.s1_pc    = e.s0_pc + 4;
        rng = xorshift32(rng);
        e.s0_inst = rng;
        rng = xorshift32(rng);
        e.s1_inst = rng;
        rng = xorshift32(rng);
        e.s0_data = rng;
        rng = xorshift32(rng);
        e.s1_data = rng;
        rng = xorshift32(rng);
        e.s0_badv = {badv_hi, rng[30:0]};
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // last two columns say whether the fault loads badv and vppn
        // normal commits, equal rd in one pair, writes to r0
        add_entry(0, 1'b1, 1'b1, 5'd1,  5'd2,  EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(0, 1'b1, 1'b1, 5'd3,  5'd3,  EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(0, 1'b1, 1'b1, 5'd0,  5'd4,  EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(0, 1'b1, 1'b0, 5'd5,  5'd6,  EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(0, 1'b0, 1'b1, 5'd7,  5'd8,  EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(0, 1'b1, 1'b1, 5'd9,  5'd10, EXP_NONE, 1'b1, 1'b0, 1'b0);
        add_entry(1, 1'b1, 1'b1, 5'd11, 5'd12, EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(1, 1'b1, 1'b1, 5'd13, 5'd14, EXP_SYS,  1'b0, 1'b0, 1'b0);
        add_entry(2, 1'b1, 1'b1, 5'd15, 5'd16, EXP_TLBR, 1'b1, 1'b1, 1'b1);
        add_entry(3, 1'b1, 1'b1, 5'd17, 5'd18, EXP_ALE,  1'b0, 1'b1, 1'b0);
        add_entry(4, 1'b1, 1'b1, 5'd19, 5'd20, EXP_INE,  1'b1, 1'b0, 1'b0);
        // younger pairs right behind a fault
        add_entry(5, 1'b1, 1'b1, 5'd21, 5'd22, EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(5, 1'b1, 1'b1, 5'd23, 5'd24, EXP_PIL,  1'b0, 1'b1, 1'b1);
        add_entry(5, 1'b1, 1'b1, 5'd25, 5'd26, EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(5, 1'b1, 1'b1, 5'd27, 5'd28, EXP_NONE, 1'b0, 1'b0, 1'b0);
        add_entry(5, 1'b1, 1'b0, 5'd29, 5'd30, EXP_NONE, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 10; i++)
            add_entry(6, 1'b1, 1'b1, 5'(3 * i + 1), 5'(31 - 2 * i), EXP_NONE, 1'b0,
                      1'b0, 1'b0);
    endtask

    function automatic logic has_next(input int grp);
        return next_idx < tbl.size() && tbl[next_idx].grp == grp;
    endfunction

    task automatic check_csr();
        check_val("csr_era", csr_era, m_era);
        check_val("csr_ecode", 32'(csr_ecode), 32'(m_ecode));
        check_val("csr_badv", csr_badv, m_badv);
        check_val("csr_pgd", csr_pgd, m_pgd);
        check_val("csr_vppn", 32'(csr_vppn), 32'(m_vppn));
        check_val("csr_direct_mode", 32'(csr_direct_mode), 32'(m_direct));
    endtask

    task automatic model_exception(input int head);
        ecode_t code;
        word_t  bv;
        code   = tbl[head].s0_ecode;
        bv     = tbl[head].s0_badv;
        m_era   = tbl[head].s0_pc;
        m_ecode = code;
        if (tbl[head].upd_badv) begin
            m_badv = bv;
            m_pgd  = bv[31] ? PGDH : PGDL;
        end
        if (tbl[head].upd_vppn)
            m_vppn = bv[31:13];
        if (code == EXP_TLBR)
            m_direct = 1'b1;
        exp_redir_pc = (code == EXP_TLBR) ? TLBRENTRY : EENTRY;
    endtask

    // ------------------------------------------------------------------------
    // per-cycle checking against the model
    // ------------------------------------------------------------------------

    task automatic check_cycle(input int cur);
        int   head;
        int   freed;
        logic exc;
        logic exp_wen0;
        logic exp_wen1;
        head     = -1;
        exc      = 1'b0;
        exp_wen0 = 1'b0;
        exp_wen1 = 1'b0;
        check_val("redirect_valid", 32'(redirect_valid), 32'(exp_redir));
        if (exp_redir)
            check_val("redirect_pc", redirect_pc, exp_redir_pc);
        check_csr();
        if (model_q.size() != 0) begin
            head = model_q[0];
            exc  = tbl[head].s0_valid && (tbl[head].s0_ecode != EXP_NONE);
            if (!exc) begin
                exp_wen0 = tbl[head].s0_valid;
                exp_wen1 = tbl[head].s1_valid;
            end
        end
        check_val("dbg0_wen", 32'(dbg0_wen), 32'(exp_wen0));
        check_val("dbg1_wen", 32'(dbg1_wen), 32'(exp_wen1));
        if (exp_wen0) begin
            check_val("dbg0_pc", dbg0_pc, tbl[head].s0_pc);
            check_val("dbg0_inst", dbg0_inst, tbl[head].s0_inst);
            check_val("dbg0_wnum", 32'(dbg0_wnum), 32'(tbl[head].s0_rd));
            check_val("dbg0_wdata", dbg0_wdata, tbl[head].s0_data);
        end
        if (exp_wen1) begin
            check_val("dbg1_pc", dbg1_pc, tbl[head].s1_pc);
            check_val("dbg1_inst", dbg1_inst, tbl[head].s1_inst);
            check_val("dbg1_wnum", 32'(dbg1_wnum), 32'(tbl[head].s1_rd));
            check_val("dbg1_wdata", dbg1_wdata, tbl[head].s1_data);
        end

        // a flush frees the queue and the pair arriving with it
        if (exc)
            freed = model_q.size() + ((cur >= 0) ? 1 : 0);
        else
            freed = (head >= 0) ? 1 : 0;
        check_val("credit_return", 32'(credit_return), 32'(freed));
        credits        += int'(credit_return);
        returned_total += int'(credit_return);
        assert (credits <= QUEUE_DEPTH) else begin
            $display("credit counter rose to %0d, above the queue depth", credits);
            errors++;
        end

        exp_redir = exc;
        if (exc) begin
            model_exception(head);
            model_q.delete();
        end else begin
            if (head >= 0) begin
                head = model_q.pop_front();
                if (exp_wen0 && tbl[head].s0_rd != 5'd0)
                    model_rf[tbl[head].s0_rd] = tbl[head].s0_data;
                if (exp_wen1 && tbl[head].s1_rd != 5'd0)
                    model_rf[tbl[head].s1_rd] = tbl[head].s1_data;
            end
            if (cur >= 0)
                model_q.push_back(cur);
        end
    endtask

    task automatic tick(input int grp);
        int cur;
        cur = -1;
        @(posedge clk);
        if (has_next(grp) && credits > 0) begin
            cur = next_idx;
            next_idx++;
            credits--;
            sent_total++;
            in_valid    <= 1'b1;
            in_s0_valid <= tbl[cur].s0_valid;
            in_s1_valid <= tbl[cur].s1_valid;
            in_s0_pc    <= tbl[cur].s0_pc;
            in_s1_pc    <= tbl[cur].s1_pc;
            in_s0_inst  <= tbl[cur].s0_inst;
            in_s1_inst  <= tbl[cur].s1_inst;
            in_s0_data  <= tbl[cur].s0_data;
            in_s1_data  <= tbl[cur].s1_data;
            in_s0_badv  <= tbl[cur].s0_badv;
            in_s0_rd    <= tbl[cur].s0_rd;
            in_s1_rd    <= tbl[cur].s1_rd;
            in_s0_ecode <= tbl[cur].s0_ecode;
        end else begin
            in_valid <= 1'b0;
        end
        @(negedge clk);
        check_cycle(cur);
    endtask

    task automatic read_back();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            in_valid <= 1'b0;
            rf_raddr <= 5'(r);
            @(negedge clk);
            check_val($sformatf("rf_rdata r%0d", r), rf_rdata, model_rf[r]);
        end
    endtask

    task automatic run_test(input int grp, input string name, input logic read_regs);
        int err0;
        int sent0;
        int ret0;
        err0  = errors;
        sent0 = sent_total;
        ret0  = returned_total;
        do begin
            tick(grp);
        end while (has_next(grp) || model_q.size() != 0 || exp_redir);
        check_val("credits", 32'(credits), 32'(QUEUE_DEPTH));
        check_val("credit_return total", 32'(returned_total - ret0), 32'(sent_total - sent0));
        if (read_regs)
            read_back();
        tests++;
        if (errors == err0) begin
            $display("test %0d %s: ok", grp, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", grp, name, errors - err0);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        rng = 32'h32db;
        build_table();
        timeout_limit = 40 * tbl.size() + 100;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_s0_valid = 1'b0;
        in_s1_valid = 1'b0;
        in_s0_pc    = '0;
        in_s1_pc    = '0;
        in_s0_inst  = '0;
        in_s1_inst  = '0;
        in_s0_data  = '0;
        in_s1_data  = '0;
        in_s0_badv  = '0;
        in_s0_rd    = '0;
        in_s1_rd    = '0;
        in_s0_ecode = '0;
        eentry      = EENTRY;
        tlbrentry   = TLBRENTRY;
        pgdl        = PGDL;
        pgdh        = PGDH;
        rf_raddr    = '0;
        for (int i = 0; i < 32; i++)
            model_rf[i] = '0;
        m_era        = '0;
        m_badv       = '0;
        m_pgd        = '0;
        m_ecode      = '0;
        m_vppn       = '0;
        m_direct     = 1'b0;
        exp_redir    = 1'b0;
        exp_redir_pc = '0;
        credits = QUEUE_DEPTH;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_val("credit_return", 32'(credit_return), 32'h0);
        check_val("dbg0_wen", 32'(dbg0_wen), 32'h0);
        check_val("dbg1_wen", 32'(dbg1_wen), 32'h0);
        check_val("redirect_valid", 32'(redirect_valid), 32'h0);
        check_csr();
        @(posedge clk);
        rst_n <= 1'b1;

        run_test(0, "normal commits", 1'b1);
        run_test(1, "exception blocks both slots", 1'b0);
        run_test(2, "tlb refill", 1'b0);
        run_test(3, "misaligned access", 1'b0);
        run_test(4, "illegal instruction", 1'b0);
        run_test(5, "flush of younger pairs", 1'b0);
        run_test(6, "back-to-back traffic", 1'b1);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/commit_queue.sv
`default_nettype none

module commit_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic                             flush,
    input  logic                             in_s0_valid,
    input  logic                             in_s1_valid,
    input  wb_pkg::word_t                    in_s0_pc,
    input  wb_pkg::word_t                    in_s1_pc,
    input  wb_pkg::word_t                    in_s0_inst,
    input  wb_pkg::word_t                    in_s1_inst,
    input  wb_pkg::word_t                    in_s0_data,
    input  wb_pkg::word_t                    in_s1_data,
    input  wb_pkg::word_t                    in_s0_badv,
    input  wb_pkg::reg_addr_t                in_s0_rd,
    input  wb_pkg::reg_addr_t                in_s1_rd,
    input  wb_pkg::ecode_t                   in_s0_ecode,
    output logic                             head_valid,
    output logic                             head_s0_valid,
    output logic                             head_s1_valid,
    output wb_pkg::word_t                    head_s0_pc,
    output wb_pkg::word_t                    head_s1_pc,
    output wb_pkg::word_t                    head_s0_inst,
    output wb_pkg::word_t                    head_s1_inst,
    output wb_pkg::word_t                    head_s0_data,
    output wb_pkg::word_t                    head_s1_data,
    output wb_pkg::word_t                    head_s0_badv,
    output wb_pkg::reg_addr_t                head_s0_rd,
    output wb_pkg::reg_addr_t                head_s1_rd,
    output wb_pkg::ecode_t                   head_s0_ecode,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] credit_return
);
    import wb_pkg::*;

    localparam int PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int CNT_W   = $clog2(QUEUE_DEPTH + 1);
    localparam int ENTRY_W = 2 + 7 * $bits(word_t) + 2 * $bits(reg_addr_t) + $bits(ecode_t);

    logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               push;
    logic               pop;

    assign full       = (count == CNT_W'(QUEUE_DEPTH));
    assign head_valid = (count != '0);
    // writeback never stalls, so the head leaves every cycle it is shown
    assign pop        = head_valid;
    assign push       = in_valid && !full && !flush;

    // a flush frees the whole queue plus a pair arriving alongside it
    always_comb begin
        if (flush)
            credit_return = count + CNT_W'(in_valid && !full);
        else
            credit_return = CNT_W'(pop);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= wr_ptr;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in_s0_valid, in_s1_valid, in_s0_pc, in_s1_pc,
                            in_s0_inst, in_s1_inst, in_s0_data, in_s1_data,
                            in_s0_badv, in_s0_rd, in_s1_rd, in_s0_ecode};
        end
    end

    assign {head_s0_valid, head_s1_valid, head_s0_pc, head_s1_pc,
            head_s0_inst, head_s1_inst, head_s0_data, head_s1_data,
            head_s0_badv, head_s0_rd, head_s1_rd, head_s0_ecode} = mem[rd_ptr];

    // ------------------------------------------------------------------------
    // credit protocol
    // ------------------------------------------------------------------------

    // upstream must hold a credit for every pair it presents
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !full);

endmodule

`default_nettype wire

//--- source/exception_csr.sv
`default_nettype none

module exception_csr (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           exc_take,
    input  logic           badv_wen,
    input  logic           vppn_wen,
    input  logic           pgd_sel_high,
    input  logic           tlb_refill,
    input  wb_pkg::word_t  era,
    input  wb_pkg::word_t  badv,
    input  wb_pkg::ecode_t ecode,
    input  wb_pkg::word_t  eentry,
    input  wb_pkg::word_t  tlbrentry,
    input  wb_pkg::word_t  pgdl,
    input  wb_pkg::word_t  pgdh,
    output wb_pkg::word_t  csr_era,
    output wb_pkg::word_t  csr_badv,
    output wb_pkg::pgd_t   csr_pgd,
    output wb_pkg::ecode_t csr_ecode,
    output wb_pkg::vppn_t  csr_vppn,
    output logic           csr_direct_mode,
    output logic           redirect_valid,
    output wb_pkg::word_t  redirect_pc
);

    // ------------------------------------------------------------------------
    // exception state
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_era         <= '0;
            csr_ecode       <= '0;
            csr_badv        <= '0;
            csr_pgd         <= '0;
            csr_vppn        <= '0;
            csr_direct_mode <= 1'b0;
        end else begin
            if (exc_take) begin
                csr_era   <= era;
                csr_ecode <= ecode;
            end
            if (badv_wen) begin
                csr_badv <= badv;
                // upper half of the address space walks from pgdh
                csr_pgd  <= pgd_sel_high ? pgdh : pgdl;
            end
            if (vppn_wen)
                csr_vppn <= badv[31:13];
            // refill handler runs untranslated
            if (tlb_refill)
                csr_direct_mode <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // redirect
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            redirect_valid <= exc_take;
            if (exc_take)
                redirect_pc <= tlb_refill ? tlbrentry : eentry;
        end
    end

    // the queue is flushed with the fault, so no second fault can follow at once
    a_single_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid);

endmodule

`default_nettype wire

//--- source/regfile.sv
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wen0,
    input  logic              wen1,
    input  wb_pkg::reg_addr_t waddr0,
    input  wb_pkg::reg_addr_t waddr1,
    input  wb_pkg::word_t     wdata0,
    input  wb_pkg::word_t     wdata1,
    input  wb_pkg::reg_addr_t raddr,
    output wb_pkg::word_t     rdata
);
    import wb_pkg::*;

    // r0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else begin
            if (wen0 && waddr0 != '0)
                regs[waddr0] <= wdata0;
            // younger slot is assigned last and wins on the same register
            if (wen1 && waddr1 != '0)
                regs[waddr1] <= wdata1;
        end
    end

    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

`default_nettype wire

//--- source/wb_core.sv
`default_nettype none

module wb_core #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic                             in_s0_valid,
    input  logic                             in_s1_valid,
    input  wb_pkg::word_t                    in_s0_pc,
    input  wb_pkg::word_t                    in_s1_pc,
    input  wb_pkg::word_t                    in_s0_inst,
    input  wb_pkg::word_t                    in_s1_inst,
    input  wb_pkg::word_t                    in_s0_data,
    input  wb_pkg::word_t                    in_s1_data,
    input  wb_pkg::word_t                    in_s0_badv,
    input  wb_pkg::reg_addr_t                in_s0_rd,
    input  wb_pkg::reg_addr_t                in_s1_rd,
    input  wb_pkg::ecode_t                   in_s0_ecode,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0] credit_return,
    input  wb_pkg::word_t                    eentry,
    input  wb_pkg::word_t                    tlbrentry,
    input  wb_pkg::word_t                    pgdl,
    input  wb_pkg::word_t                    pgdh,
    input  wb_pkg::reg_addr_t                rf_raddr,
    output wb_pkg::word_t                    rf_rdata,
    output wb_pkg::word_t                    dbg0_pc,
    output wb_pkg::word_t                    dbg0_inst,
    output wb_pkg::word_t                    dbg0_wdata,
    output wb_pkg::reg_addr_t                dbg0_wnum,
    output logic                             dbg0_wen,
    output wb_pkg::word_t                    dbg1_pc,
    output wb_pkg::word_t                    dbg1_inst,
    output wb_pkg::word_t                    dbg1_wdata,
    output wb_pkg::reg_addr_t                dbg1_wnum,
    output logic                             dbg1_wen,
    output wb_pkg::word_t                    csr_era,
    output wb_pkg::word_t                    csr_badv,
    output wb_pkg::pgd_t                     csr_pgd,
    output wb_pkg::ecode_t                   csr_ecode,
    output wb_pkg::vppn_t                    csr_vppn,
    output logic                             csr_direct_mode,
    output logic                             redirect_valid,
    output wb_pkg::word_t                    redirect_pc
);
    import wb_pkg::*;

    // head of the queue
    logic      head_valid;
    logic      head_s0_valid;
    logic      head_s1_valid;
    word_t     head_s0_pc;
    word_t     head_s1_pc;
    word_t     head_s0_inst;
    word_t     head_s1_inst;
    word_t     head_s0_data;
    word_t     head_s1_data;
    word_t     head_s0_badv;
    reg_addr_t head_s0_rd;
    reg_addr_t head_s1_rd;
    ecode_t    head_s0_ecode;

    // register writes
    logic      wen0;
    logic      wen1;
    reg_addr_t waddr0;
    reg_addr_t waddr1;
    word_t     wdata0;
    word_t     wdata1;

    // exception path
    logic      exc_take;
    logic      badv_wen;
    logic      vppn_wen;
    logic      pgd_sel_high;
    logic      tlb_refill;
    logic      flush;
    word_t     era;
    word_t     badv;
    ecode_t    ecode;

    commit_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_commit_queue (.*);

    writeback i_writeback (.*);

    regfile i_regfile (
        .*,
        .raddr(rf_raddr),
        .rdata(rf_rdata)
    );

    exception_csr i_exception_csr (.*);

endmodule

`default_nettype wire

//--- source/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  ecode_t;
    typedef logic [18:0] vppn_t;
    typedef logic [31:0] pgd_t;

    // bits 5:0 hold the architectural ecode and bit 6 the esubcode
    // interrupts are tagged with bit 6 because an all-zero code means no exception
    typedef enum ecode_t {
        EXP_NONE = 7'h00,
        EXP_INT  = 7'h40,
        EXP_PIL  = 7'h01,
        EXP_PIS  = 7'h02,
        EXP_PIF  = 7'h03,
        EXP_PME  = 7'h04,
        EXP_PPI  = 7'h07,
        EXP_ADEF = 7'h08,
        EXP_ADEM = 7'h48,
        EXP_ALE  = 7'h09,
        EXP_SYS  = 7'h0b,
        EXP_BRK  = 7'h0c,
        EXP_INE  = 7'h0d,
        EXP_TLBR = 7'h3f
    } exp_code_e;

    // ------------------------------------------------------------------------
    // exception classes
    // ------------------------------------------------------------------------

    // address faults report the faulting address in badv
    function automatic logic sets_badv(ecode_t code);
        case (code)
            EXP_TLBR, EXP_ADEF, EXP_ADEM, EXP_ALE, EXP_PIL, EXP_PIS,
            EXP_PIF, EXP_PME, EXP_PPI:
                sets_badv = 1'b1;
            default:
                sets_badv = 1'b0;
        endcase
    endfunction

    // only the TLB related faults load the page number as well
    function automatic logic sets_vppn(ecode_t code);
        case (code)
            EXP_TLBR, EXP_PIL, EXP_PIS, EXP_PIF, EXP_PME, EXP_PPI:
                sets_vppn = 1'b1;
            default:
                sets_vppn = 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/writeback.sv
`default_nettype none

module writeback (
    input  logic              head_valid,
    input  logic              head_s0_valid,
    input  logic              head_s1_valid,
    input  wb_pkg::word_t     head_s0_pc,
    input  wb_pkg::word_t     head_s1_pc,
    input  wb_pkg::word_t     head_s0_inst,
    input  wb_pkg::word_t     head_s1_inst,
    input  wb_pkg::word_t     head_s0_data,
    input  wb_pkg::word_t     head_s1_data,
    input  wb_pkg::word_t     head_s0_badv,
    input  wb_pkg::reg_addr_t head_s0_rd,
    input  wb_pkg::reg_addr_t head_s1_rd,
    input  wb_pkg::ecode_t    head_s0_ecode,
    // register file
    output logic              wen0,
    output logic              wen1,
    output wb_pkg::reg_addr_t waddr0,
    output wb_pkg::reg_addr_t waddr1,
    output wb_pkg::word_t     wdata0,
    output wb_pkg::word_t     wdata1,
    // exception state
    output logic              exc_take,
    output logic              badv_wen,
    output logic              vppn_wen,
    output logic              pgd_sel_high,
    output logic              tlb_refill,
    output wb_pkg::word_t     era,
    output wb_pkg::word_t     badv,
    output wb_pkg::ecode_t    ecode,
    output logic              flush,
    // debug trace
    output wb_pkg::word_t     dbg0_pc,
    output wb_pkg::word_t     dbg0_inst,
    output wb_pkg::word_t     dbg0_wdata,
    output wb_pkg::reg_addr_t dbg0_wnum,
    output logic              dbg0_wen,
    output wb_pkg::word_t     dbg1_pc,
    output wb_pkg::word_t     dbg1_inst,
    output wb_pkg::word_t     dbg1_wdata,
    output wb_pkg::reg_addr_t dbg1_wnum,
    output logic              dbg1_wen
);
    import wb_pkg::*;

    logic exc;

    // only the older slot can fault
    assign exc = head_valid && head_s0_valid && (head_s0_ecode != EXP_NONE);

    // a fault in slot 0 squashes the younger slot of the same pair too
    assign wen0   = head_valid && head_s0_valid && !exc;
    assign wen1   = head_valid && head_s1_valid && !exc;
    assign waddr0 = head_s0_rd;
    assign waddr1 = head_s1_rd;
    assign wdata0 = head_s0_data;
    assign wdata1 = head_s1_data;

    assign exc_take     = exc;
    assign flush        = exc;
    assign era          = head_s0_pc;
    assign ecode        = head_s0_ecode;
    assign badv         = head_s0_badv;
    assign badv_wen     = exc && sets_badv(head_s0_ecode);
    assign vppn_wen     = exc && sets_vppn(head_s0_ecode);
    assign pgd_sel_high = head_s0_badv[31];
    assign tlb_refill   = exc && (head_s0_ecode == EXP_TLBR);

    assign dbg0_pc    = head_s0_pc;
    assign dbg0_inst  = head_s0_inst;
    assign dbg0_wdata = head_s0_data;
    assign dbg0_wnum  = head_s0_rd;
    assign dbg0_wen   = wen0;
    assign dbg1_pc    = head_s1_pc;
    assign dbg1_inst  = head_s1_inst;
    assign dbg1_wdata = head_s1_data;
    assign dbg1_wnum  = head_s1_rd;
    assign dbg1_wen   = wen1;

endmodule

`default_nettype wire

//--- vlog.f
source/wb_pkg.sv
source/commit_queue.sv
source/writeback.sv
source/regfile.sv
source/exception_csr.sv
source/wb_core.sv
sim/tb_wb_core.sv
